/* design/axi_pkg.sv */
`include "fb_params.svh"

package axi_pkg;

  // AW channel payload
  typedef struct packed {
    logic [`FB_AXI_ADDR_BITS-1:0] addr;
  } axi_aw_t;

  // W channel payload, one strobe bit per byte
  typedef struct packed {
    logic [`FB_AXI_DATA_BITS-1:0]   data;
    logic [`FB_AXI_DATA_BITS/8-1:0] strb;
  } axi_w_t;

  // B channel response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // Writer FSM
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_SEND = 2'd1,
    WR_RESP = 2'd2
  } writer_state_e;

endpackage

/* design/fb_arbiter_2to1.sv */
`timescale 1ns/1ps

module fb_arbiter_2to1 (
  input  logic                 clk,
  input  logic                 reset,

  // Source 0, higher priority
  input  logic                 in0_valid,
  output logic                 in0_ready,
  input  pixel_pkg::pixel_req_t in0_req,

  // Source 1
  input  logic                 in1_valid,
  output logic                 in1_ready,
  input  pixel_pkg::pixel_req_t in1_req,

  // Towards the writer
  output logic                 pix_valid,
  input  logic                 pix_ready,
  output pixel_pkg::pixel_req_t pix_req
);

  import pixel_pkg::*;

  grant_e grant;
  logic   stalled;

  // Offered pixel not yet taken by the writer
  assign stalled = pix_valid && !pix_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= GRANT_IDLE;
    end else if (!stalled) begin
      if (in0_valid) begin
        grant <= GRANT_IN0;
      end else if (in1_valid) begin
        grant <= GRANT_IN1;
      end else begin
        grant <= GRANT_IDLE;
      end
    end
  end

  // Mux the granted source
  always_comb begin
    case (grant)
      GRANT_IN0: begin
        pix_valid = in0_valid;
        pix_req   = in0_req;
      end
      GRANT_IN1: begin
        pix_valid = in1_valid;
        pix_req   = in1_req;
      end
      default: begin
        pix_valid = 1'b0;
        pix_req   = in0_req;
      end
    endcase
  end

  // Ready goes back to the granted source only
  assign in0_ready = (grant == GRANT_IN0) && pix_ready;
  assign in1_ready = (grant == GRANT_IN1) && pix_ready;

endmodule

/* design/fb_params.svh */
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// Pixel side
`define FB_PIXEL_BITS 12
`define FB_PIX_ADDR_BITS 19

// AXI4-Lite side
`define FB_AXI_ADDR_BITS 20
`define FB_AXI_DATA_BITS 16

// Byte address is pixel index times this
`define FB_BYTES_PER_WORD 2

// Saturating error response counter
`define FB_ERR_COUNT_BITS 16

`endif

/* design/fb_write_path.sv */
`timescale 1ns/1ps

`include "fb_params.svh"

module fb_write_path (
  input  logic                          clk,
  input  logic                          reset,

  // Pixel source 0
  input  logic                          in0_valid,
  output logic                          in0_ready,
  input  pixel_pkg::pixel_req_t         in0_req,

  // Pixel source 1
  input  logic                          in1_valid,
  output logic                          in1_ready,
  input  pixel_pkg::pixel_req_t         in1_req,

  // AXI4-Lite write port to the framebuffer memory
  output axi_pkg::axi_aw_t              aw,
  output logic                          aw_valid,
  input  logic                          aw_ready,
  output axi_pkg::axi_w_t               w,
  output logic                          w_valid,
  input  logic                          w_ready,
  input  axi_pkg::axi_resp_e            b_resp,
  input  logic                          b_valid,
  output logic                          b_ready,

  output logic [`FB_ERR_COUNT_BITS-1:0] write_errors
);

  import pixel_pkg::*;

  // Arbitrated pixel stream
  logic       pix_valid;
  logic       pix_ready;
  pixel_req_t pix_req;

  fb_arbiter_2to1 arb0 (
    .clk       (clk),
    .reset     (reset),
    .in0_valid (in0_valid),
    .in0_ready (in0_ready),
    .in0_req   (in0_req),
    .in1_valid (in1_valid),
    .in1_ready (in1_ready),
    .in1_req   (in1_req),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .pix_req   (pix_req)
  );

  fb_writer wr0 (
    .clk          (clk),
    .reset        (reset),
    .pix_valid    (pix_valid),
    .pix_req      (pix_req),
    .pix_ready    (pix_ready),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b_resp       (b_resp),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .write_errors (write_errors)
  );

endmodule

/* design/fb_writer.sv */
`timescale 1ns/1ps

`include "fb_params.svh"

module fb_writer (
  input  logic                          clk,
  input  logic                          reset,

  // Pixel stream from the arbiter
  input  logic                          pix_valid,
  input  pixel_pkg::pixel_req_t         pix_req,
  output logic                          pix_ready,

  // AXI4-Lite write address
  output axi_pkg::axi_aw_t              aw,
  output logic                          aw_valid,
  input  logic                          aw_ready,

  // AXI4-Lite write data
  output axi_pkg::axi_w_t               w,
  output logic                          w_valid,
  input  logic                          w_ready,

  // AXI4-Lite write response
  input  axi_pkg::axi_resp_e            b_resp,
  input  logic                          b_valid,
  output logic                          b_ready,

  output logic [`FB_ERR_COUNT_BITS-1:0] write_errors
);

  import axi_pkg::*;

  writer_state_e state;

  logic pix_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  // Per-channel completion, either may finish first
  logic aw_done;
  logic w_done;
  logic aw_complete;
  logic w_complete;

  logic resp_err;

  assign pix_ready = (state == WR_IDLE);

  assign pix_fire = pix_valid && pix_ready;
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  assign b_fire   = b_valid && b_ready;

  assign aw_complete = aw_done || aw_fire;
  assign w_complete  = w_done || w_fire;

  assign resp_err = (b_resp == RESP_SLVERR) || (b_resp == RESP_DECERR);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= WR_IDLE;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      b_ready  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (pix_fire) begin
            state    <= WR_SEND;
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
          end
        end

        WR_SEND: begin
          if (aw_fire) begin
            aw_valid <= 1'b0;
            aw_done  <= 1'b1;
          end
          if (w_fire) begin
            w_valid <= 1'b0;
            w_done  <= 1'b1;
          end
          // Both channels through, wait for the response
          if (aw_complete && w_complete) begin
            state   <= WR_RESP;
            b_ready <= 1'b1;
          end
        end

        WR_RESP: begin
          if (b_fire) begin
            state   <= WR_IDLE;
            b_ready <= 1'b0;
          end
        end

        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // Address and data, held until both channels accept
  always_ff @(posedge clk) begin
    if (pix_fire) begin
      aw.addr <= `FB_AXI_ADDR_BITS'(pix_req.pix_index * `FB_BYTES_PER_WORD);
      w.data  <= `FB_AXI_DATA_BITS'(pix_req.color);
      w.strb  <= '1;
    end
  end

  // Error responses, saturating
  always_ff @(posedge clk) begin
    if (reset) begin
      write_errors <= '0;
    end else if (b_fire && resp_err && (write_errors != '1)) begin
      write_errors <= write_errors + 1'b1;
    end
  end

endmodule

/* design/pixel_pkg.sv */
`include "fb_params.svh"

package pixel_pkg;

  // One pixel write as offered by a producer
  typedef struct packed {
    logic [`FB_PIX_ADDR_BITS-1:0] pix_index;
    logic [`FB_PIXEL_BITS-1:0]    color;
  } pixel_req_t;

  // Arbiter grant, idle means nothing is passed on
  typedef enum logic [1:0] {
    GRANT_IN0  = 2'd0,
    GRANT_IN1  = 2'd1,
    GRANT_IDLE = 2'd2
  } grant_e;

endpackage

/* list.f */
+incdir+design
design/pixel_pkg.sv
design/axi_pkg.sv
design/fb_arbiter_2to1.sv
design/fb_writer.sv
design/fb_write_path.sv
test/fb_axi_slave_model.sv
test/tb_fb_write_path.sv

/* run.sh */
#!/bin/sh
# Build and run the framebuffer write path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f list.f \
  --top-module tb_fb_write_path \
  --Mdir obj_dir -o tb_fb_write_path

out=$(./obj_dir/tb_fb_write_path)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
else
  exit 1
fi

/* test/fb_axi_slave_model.sv */
`timescale 1ns/1ps

module fb_axi_slave_model (
  input  logic               clk,
  input  logic               reset,

  // AXI4-Lite write channels from the DUT
  input  axi_pkg::axi_aw_t   aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axi_pkg::axi_w_t    w,
  input  logic               w_valid,
  output logic               w_ready,
  output axi_pkg::axi_resp_e b_resp,
  output logic               b_valid,
  input  logic               b_ready,

  // One-cycle pulse per completed write
  output logic               rec_valid,
  output axi_pkg::axi_aw_t   rec_aw,
  output axi_pkg::axi_w_t    rec_w,
  output axi_pkg::axi_resp_e rec_resp
);

  import axi_pkg::*;

  integer seed = 32'h2c901695;

  // Remaining wait cycles per channel, drawn fresh for each write
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] b_wait;
  logic       aw_got;
  logic       w_got;

  always @(posedge clk) begin
    if (reset) begin
      aw_ready  <= 1'b0;
      w_ready   <= 1'b0;
      b_valid   <= 1'b0;
      b_resp    <= RESP_OKAY;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      aw_wait   <= 2'($random(seed));
      w_wait    <= 2'($random(seed));
      b_wait    <= 2'($random(seed));
      rec_valid <= 1'b0;
      rec_aw    <= '0;
      rec_w     <= '0;
      rec_resp  <= RESP_OKAY;
    end else begin
      rec_valid <= 1'b0;

      if (aw_valid && aw_ready) begin
        aw_ready <= 1'b0;
        aw_got   <= 1'b1;
        rec_aw   <= aw;
      end else if (aw_valid && !aw_got) begin
        if (aw_wait == 2'd0) begin
          aw_ready <= 1'b1;
        end else begin
          aw_wait <= aw_wait - 2'd1;
        end
      end

      if (w_valid && w_ready) begin
        w_ready <= 1'b0;
        w_got   <= 1'b1;
        rec_w   <= w;
      end else if (w_valid && !w_got) begin
        if (w_wait == 2'd0) begin
          w_ready <= 1'b1;
        end else begin
          w_wait <= w_wait - 2'd1;
        end
      end

      // Response once address and data are both in
      if (b_valid && b_ready) begin
        b_valid   <= 1'b0;
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
        rec_valid <= 1'b1;
        rec_resp  <= b_resp;
        aw_wait   <= 2'($random(seed));
        w_wait    <= 2'($random(seed));
        b_wait    <= 2'($random(seed));
      end else if (aw_got && w_got && !b_valid) begin
        if (b_wait == 2'd0) begin
          b_valid <= 1'b1;
          // Roughly one in eight writes fails
          b_resp  <= (3'($random(seed)) == 3'd0) ? RESP_SLVERR : RESP_OKAY;
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
    end
  end

endmodule

/* test/tb_fb_write_path.sv */
`timescale 1ns/1ps

`include "fb_params.svh"

module tb_fb_write_path;

  import pixel_pkg::*;
  import axi_pkg::*;

  localparam int run_limit     = 20000;
  localparam int drain_limit   = 2000;
  localparam int random_pixels = 200;

  logic       clk = 1'b0;
  logic       reset;
  logic       in0_valid;
  logic       in0_ready;
  pixel_req_t in0_req;
  logic       in1_valid;
  logic       in1_ready;
  pixel_req_t in1_req;

  axi_aw_t   aw;
  logic      aw_valid;
  logic      aw_ready;
  axi_w_t    w;
  logic      w_valid;
  logic      w_ready;
  axi_resp_e b_resp;
  logic      b_valid;
  logic      b_ready;
  logic [`FB_ERR_COUNT_BITS-1:0] write_errors;

  logic      rec_valid;
  axi_aw_t   rec_aw;
  axi_w_t    rec_w;
  axi_resp_e rec_resp;

  integer seed;
  int     check_errors = 0;
  int     errors_at_test_start = 0;
  int     tests_failed = 0;

  // Scoreboard, only the monitor writes these
  pixel_req_t exp0_q[$];
  pixel_req_t exp1_q[$];
  bit         written_src_q[$];
  int         rec_count = 0;
  int         model_errors = 0;
  int         record_errors = 0;

  // Pixels each source has yet to offer
  pixel_req_t pend0_q[$];
  pixel_req_t pend1_q[$];

  fb_write_path dut0 (
    .clk          (clk),
    .reset        (reset),
    .in0_valid    (in0_valid),
    .in0_ready    (in0_ready),
    .in0_req      (in0_req),
    .in1_valid    (in1_valid),
    .in1_ready    (in1_ready),
    .in1_req      (in1_req),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b_resp       (b_resp),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .write_errors (write_errors)
  );

  fb_axi_slave_model slv0 (
    .clk       (clk),
    .reset     (reset),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b_resp    (b_resp),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .rec_valid (rec_valid),
    .rec_aw    (rec_aw),
    .rec_w     (rec_w),
    .rec_resp  (rec_resp)
  );

  always #10 clk = ~clk;

  task automatic check_record(input axi_aw_t a, input axi_w_t d, input axi_resp_e r);
    pixel_req_t                   want;
    logic                         src;
    logic [`FB_AXI_ADDR_BITS-1:0] want_addr;
    logic [`FB_AXI_DATA_BITS-1:0] want_data;
    // Source 1 indices live in the upper half
    src = a.addr[`FB_AXI_ADDR_BITS-1];
    rec_count++;
    written_src_q.push_back(src);
    if (r == RESP_SLVERR || r == RESP_DECERR) begin
      model_errors++;
    end
    if ((!src && exp0_q.size() == 0) || (src && exp1_q.size() == 0)) begin
      $display("Unexpected write at t=%0t to 0x%0h, no pixel pending on source %0d",
               $time, a.addr, src);
      record_errors++;
    end else begin
      if (src) begin
        want = exp1_q.pop_front();
      end else begin
        want = exp0_q.pop_front();
      end
      // Two bytes per word
      want_addr = {want.pix_index, 1'b0};
      want_data = {{(`FB_AXI_DATA_BITS - `FB_PIXEL_BITS){1'b0}}, want.color};
      if (a.addr !== want_addr) begin
        $display("[FAIL] t=%0t aw.addr expected 0x%0h got 0x%0h", $time, want_addr, a.addr);
        record_errors++;
      end
      if (d.data !== want_data) begin
        $display("[FAIL] t=%0t w.data expected 0x%0h got 0x%0h", $time, want_data, d.data);
        record_errors++;
      end
      if (d.strb !== {(`FB_AXI_DATA_BITS/8){1'b1}}) begin
        $display("[FAIL] t=%0t w.strb expected 0x3 got 0x%0h", $time, d.strb);
        record_errors++;
      end
    end
  endtask

  // Accepted pixels become expected writes
  always @(posedge clk) begin
    if (!reset) begin
      if (in0_valid && in0_ready) begin
        exp0_q.push_back(in0_req);
      end
      if (in1_valid && in1_ready) begin
        exp1_q.push_back(in1_req);
      end
      if (rec_valid) begin
        check_record(rec_aw, rec_w, rec_resp);
      end
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    int found;
    found = check_errors + record_errors - errors_at_test_start;
    if (found == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d wrong", num, name, found);
      tests_failed++;
    end
    errors_at_test_start = check_errors + record_errors;
  endtask

  // Offer pending pixels, a source keeps valid up until its transfer
  task automatic run_sources(input logic [3:0] gap_level);
    int         cycles;
    logic       take0;
    logic       take1;
    logic [3:0] roll;
    cycles = 0;
    while ((pend0_q.size() != 0 || in0_valid || pend1_q.size() != 0 || in1_valid)
           && cycles < run_limit) begin
      if (!in0_valid && pend0_q.size() != 0) begin
        roll = 4'($random(seed));
        if (roll >= gap_level) begin
          in0_req   = pend0_q.pop_front();
          in0_valid = 1'b1;
        end
      end
      if (!in1_valid && pend1_q.size() != 0) begin
        roll = 4'($random(seed));
        if (roll >= gap_level) begin
          in1_req   = pend1_q.pop_front();
          in1_valid = 1'b1;
        end
      end
      take0 = in0_valid && in0_ready;
      take1 = in1_valid && in1_ready;
      step_cycle();
      cycles++;
      if (take0) begin
        in0_valid = 1'b0;
      end
      if (take1) begin
        in1_valid = 1'b0;
      end
    end
    if (pend0_q.size() != 0 || in0_valid || pend1_q.size() != 0 || in1_valid) begin
      $display("Timeout: sources still held pixels after %0d cycles", run_limit);
      check_errors++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp0_q.size() != 0 || exp1_q.size() != 0) && cycles < drain_limit) begin
      step_cycle();
      cycles++;
    end
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      $display("Timeout: %0d accepted pixels never reached the slave",
               exp0_q.size() + exp1_q.size());
      check_errors++;
    end
    // A stray extra write would show up here
    repeat (5) step_cycle();
  endtask

  initial begin
    pixel_req_t  pix;
    logic [31:0] roll;
    int          cycles;
    int          first_count;
    seed      = 32'h2c901695;
    reset     = 1'b1;
    in0_valid = 1'b0;
    in0_req   = '0;
    in1_valid = 1'b0;
    in1_req   = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (10) begin
      compare("in0_ready", 32'd0, 32'(in0_ready));
      compare("in1_ready", 32'd0, 32'(in1_ready));
      compare("aw_valid", 32'd0, 32'(aw_valid));
      compare("w_valid", 32'd0, 32'(w_valid));
      compare("b_ready", 32'd0, 32'(b_ready));
      compare("write_errors", 32'd0, 32'(write_errors));
      step_cycle();
    end
    finish_test(1, "idle after reset");

    first_count   = rec_count;
    pix.pix_index = 19'h00123;
    pix.color     = 12'habc;
    in0_req       = pix;
    in0_valid     = 1'b1;
    cycles        = 0;
    while (!in0_ready && cycles < drain_limit) begin
      step_cycle();
      cycles++;
    end
    if (!in0_ready) begin
      $display("Timeout: in0 never saw ready for a single pixel");
      check_errors++;
    end else begin
      step_cycle();
      in0_valid = 1'b0;
      // Taken on the last edge, AW and W are up one cycle later
      compare("aw_valid", 32'd1, 32'(aw_valid));
      compare("w_valid", 32'd1, 32'(w_valid));
      compare("aw.addr", 32'h00246, 32'(aw.addr));
      compare("w.data", 32'h00abc, 32'(w.data));
      compare("w.strb", 32'h3, 32'(w.strb));
    end
    in0_valid = 1'b0;
    wait_drain();
    compare("write count", 32'd1, 32'(rec_count - first_count));
    finish_test(2, "single pixel on in0");

    first_count = rec_count;
    for (int i = 0; i < 4; i++) begin
      pix.pix_index = {1'b0, 18'($random(seed))};
      pix.color     = 12'($random(seed));
      pend0_q.push_back(pix);
    end
    pix.pix_index = {1'b1, 18'($random(seed))};
    pix.color     = 12'($random(seed));
    pend1_q.push_back(pix);
    run_sources(4'd0);
    wait_drain();
    compare("write count", 32'd5, 32'(rec_count - first_count));
    if (written_src_q.size() >= first_count + 5) begin
      for (int i = 0; i < 5; i++) begin
        compare("write source", 32'(i >= 4), 32'(written_src_q[first_count + i]));
      end
    end
    finish_test(3, "in0 priority over in1");

    first_count = rec_count;
    for (int i = 0; i < random_pixels; i++) begin
      roll      = $random(seed);
      pix.color = 12'($random(seed));
      if (roll[0]) begin
        pix.pix_index = {1'b1, 18'($random(seed))};
        pend1_q.push_back(pix);
      end else begin
        pix.pix_index = {1'b0, 18'($random(seed))};
        pend0_q.push_back(pix);
      end
    end
    run_sources(4'd6);
    wait_drain();
    compare("write count", 32'(random_pixels), 32'(rec_count - first_count));
    finish_test(4, "random traffic under slave delays");

    compare("write_errors", 32'(model_errors), 32'(write_errors));
    finish_test(5, "error response count");

    $display("Tests run 5, tests failed %0d, checks wrong %0d, writes seen %0d",
             tests_failed, check_errors + record_errors, rec_count);
    if (check_errors + record_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
